//--- rtl/trace_pkg.sv
// Trace unit package: widths, vector types, privilege and mode enums, commit and trace records
package trace_pkg;

  // --------------------------------------------------
  // Configuration defaults
  // --------------------------------------------------
  // Commit ports of the core
  localparam int unsigned NrCommitPorts = 2;
  // Entries per PC queue, power of two
  localparam int unsigned PcQueueDepth  = 4;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned XLEN = 64;
  localparam int unsigned VLEN = 39;
  localparam int unsigned ILEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [VLEN-1:0] pc_t;
  typedef logic [ILEN-1:0] instr_t;
  typedef logic [63:0]     cycle_t;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  // RISC-V privilege levels, 2'b10 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Mode code in the trace record, D wins over everything
  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_S = 2'd1,
    MODE_M = 2'd2,
    MODE_D = 2'd3
  } trace_mode_e;

  // One commit port at the commit stage
  // Instruction word sits in tval[31:0]
  typedef struct packed {
    logic  ack;
    logic  ex_valid;
    xlen_t cause;   // MSB set for interrupts
    xlen_t tval;
    pc_t   pc;
  } commit_port_t;

  // One registered trace record
  typedef struct packed {
    logic        valid;
    logic        exception;
    logic        interrupt;
    pc_t         iaddr;
    instr_t      insn;
    xlen_t       cause;
    xlen_t       tval;
    trace_mode_e mode;
    cycle_t      cycle;
  } trace_rec_t;

endpackage

//--- rtl/trace_encoder.sv
// Per-port trace record builder with the free-running cycle counter
`timescale 1ns/100ps

module trace_encoder (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  trace_pkg::commit_port_t commit_i,
  input  trace_pkg::priv_lvl_e    priv_lvl_i,
  input  logic                    debug_mode_i,
  output trace_pkg::trace_rec_t   trace_o
);

  import trace_pkg::*;

  // Cycle stamp, edges since reset release
  cycle_t      cycle_q;

  // Next-record flags and mode
  logic        valid_d;
  logic        exception_d;
  logic        interrupt_d;
  trace_mode_e mode_d;

  // Registered record
  logic        valid_q;
  logic        exception_q;
  logic        interrupt_q;
  pc_t         iaddr_q;
  instr_t      insn_q;
  xlen_t       cause_q;
  xlen_t       tval_q;
  trace_mode_e mode_q;
  cycle_t      stamp_q;

  // --------------------------------------------------
  // Record classification
  // --------------------------------------------------
  assign valid_d     = commit_i.ack & ~commit_i.ex_valid;
  assign exception_d = commit_i.ack & commit_i.ex_valid & ~commit_i.cause[XLEN-1];
  assign interrupt_d = commit_i.ack & commit_i.ex_valid &  commit_i.cause[XLEN-1];

  always_comb begin
    if (debug_mode_i) begin
      mode_d = MODE_D;
    end else begin
      case (priv_lvl_i)
        PRIV_LVL_M: mode_d = MODE_M;
        PRIV_LVL_S: mode_d = MODE_S;
        PRIV_LVL_U: mode_d = MODE_U;
        // Reserved level reported as user
        default:    mode_d = MODE_U;
      endcase
    end
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q     <= '0;
      valid_q     <= 1'b0;
      exception_q <= 1'b0;
      interrupt_q <= 1'b0;
    end else begin
      cycle_q     <= cycle_q + 1'b1;
      valid_q     <= valid_d;
      exception_q <= exception_d;
      interrupt_q <= interrupt_d;
    end
  end

  // Payload captured every cycle, qualified by the flags
  always_ff @(posedge clk_i) begin
    iaddr_q <= commit_i.pc;
    insn_q  <= commit_i.tval[ILEN-1:0];
    cause_q <= commit_i.cause;
    tval_q  <= commit_i.tval;
    mode_q  <= mode_d;
    stamp_q <= cycle_q;
  end

  always_comb begin
    trace_o.valid     = valid_q;
    trace_o.exception = exception_q;
    trace_o.interrupt = interrupt_q;
    trace_o.iaddr     = iaddr_q;
    trace_o.insn      = insn_q;
    trace_o.cause     = cause_q;
    trace_o.tval      = tval_q;
    trace_o.mode      = mode_q;
    trace_o.cycle     = stamp_q;
  end

  // A record is either a trap of one kind or none
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(trace_o.exception && trace_o.interrupt))
    else $error("trace record flags both exception and interrupt");

endmodule

//--- rtl/pc_queue.sv
// FIFO of retired PCs for one commit port with overflow detection
`timescale 1ns/100ps

module pc_queue #(
  parameter int unsigned PcQueueDepth = trace_pkg::PcQueueDepth
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           push_i,
  input  trace_pkg::pc_t pc_i,
  input  logic           pop_i,
  output trace_pkg::pc_t head_o,
  output logic           empty_o,
  output logic           overflow_o
);

  import trace_pkg::*;

  localparam int unsigned AddrW = $clog2(PcQueueDepth);

  pc_t            mem_q [PcQueueDepth];
  logic [AddrW-1:0] rd_ptr_q;
  logic [AddrW-1:0] wr_ptr_q;
  logic [AddrW:0]   count_q;

  logic full;
  logic wr_en;

  assign full    = (count_q == (AddrW + 1)'(PcQueueDepth));
  assign empty_o = (count_q == '0);

  // A pop in the same cycle frees the slot for the push
  assign wr_en      = push_i & (~full | pop_i);
  assign overflow_o = push_i & full & ~pop_i;

  assign head_o = mem_q[rd_ptr_q];

  // --------------------------------------------------
  // Pointers and fill count
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= pc_i;
    end
  end

  // Arbiter only grants queues that hold an entry
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o)
    else $error("pop on empty PC queue");

endmodule

//--- rtl/pc_arbiter.sv
// Round-robin merge of the PC queue heads and the sticky overflow flag
`timescale 1ns/100ps

module pc_arbiter #(
  parameter int unsigned NrCommitPorts = trace_pkg::NrCommitPorts
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  trace_pkg::pc_t [NrCommitPorts-1:0]   head_i,
  input  logic [NrCommitPorts-1:0]             empty_i,
  input  logic [NrCommitPorts-1:0]             overflow_i,
  output logic [NrCommitPorts-1:0]             pop_o,
  output logic                                 pc_valid_o,
  output trace_pkg::pc_t                       pc_o,
  output logic                                 overflow_o
);

  import trace_pkg::*;

  localparam int unsigned PtrW = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1;

  logic [PtrW-1:0] rr_ptr_q;
  logic [PtrW-1:0] grant_idx;
  logic            grant_valid;
  logic            overflow_q;

  // --------------------------------------------------
  // Grant search starting at the pointer
  // --------------------------------------------------
  always_comb begin
    int cand;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int k = 0; k < int'(NrCommitPorts); k++) begin
      cand = int'(rr_ptr_q) + k;
      // Wrap around the port count
      if (cand >= int'(NrCommitPorts)) begin
        cand = cand - int'(NrCommitPorts);
      end
      if (!grant_valid && !empty_i[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = PtrW'(cand);
      end
    end
  end

  always_comb begin
    pop_o = '0;
    if (grant_valid) begin
      pop_o[grant_idx] = 1'b1;
    end
  end

  // Output is consumed every cycle
  assign pc_valid_o = grant_valid;
  assign pc_o       = head_i[grant_idx];
  assign overflow_o = overflow_q;

  // --------------------------------------------------
  // Pointer and sticky overflow
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q   <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (grant_valid) begin
        if (grant_idx == PtrW'(NrCommitPorts - 1)) begin
          rr_ptr_q <= '0;
        end else begin
          rr_ptr_q <= grant_idx + 1'b1;
        end
      end
      overflow_q <= overflow_q | (|overflow_i);
    end
  end

  // At most one queue pops per cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(pop_o))
    else $error("pop strobe is not one-hot");

endmodule

//--- rtl/commit_tracer.sv
// Commit-side trace unit top: per-port encoders and PC queues plus the PC stream arbiter
`timescale 1ns/100ps

module commit_tracer #(
  parameter int unsigned NrCommitPorts = trace_pkg::NrCommitPorts,
  parameter int unsigned PcQueueDepth  = trace_pkg::PcQueueDepth
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  trace_pkg::commit_port_t [NrCommitPorts-1:0] commit_i,
  input  trace_pkg::priv_lvl_e                     priv_lvl_i,
  input  logic                                     debug_mode_i,
  output trace_pkg::trace_rec_t [NrCommitPorts-1:0]   trace_o,
  output logic                                     pc_valid_o,
  output trace_pkg::pc_t                           pc_o,
  output logic                                     overflow_o
);

  import trace_pkg::*;

  // Queue heads and status towards the arbiter
  pc_t [NrCommitPorts-1:0]  pc_head;
  logic [NrCommitPorts-1:0] pc_empty;
  logic [NrCommitPorts-1:0] pc_overflow;
  logic [NrCommitPorts-1:0] pc_pop;

  // --------------------------------------------------
  // Per-port trace records and PC queues
  // --------------------------------------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_port
    trace_encoder i_trace_encoder (
      .clk_i        ( clk_i        ),
      .rst_ni       ( rst_ni       ),
      .commit_i     ( commit_i[i]  ),
      .priv_lvl_i   ( priv_lvl_i   ),
      .debug_mode_i ( debug_mode_i ),
      .trace_o      ( trace_o[i]   )
    );

    // Only clean retires enter the PC stream
    pc_queue #(
      .PcQueueDepth ( PcQueueDepth )
    ) i_pc_queue (
      .clk_i      ( clk_i                                   ),
      .rst_ni     ( rst_ni                                  ),
      .push_i     ( commit_i[i].ack & ~commit_i[i].ex_valid ),
      .pc_i       ( commit_i[i].pc                          ),
      .pop_i      ( pc_pop[i]                               ),
      .head_o     ( pc_head[i]                              ),
      .empty_o    ( pc_empty[i]                             ),
      .overflow_o ( pc_overflow[i]                          )
    );
  end

  // --------------------------------------------------
  // PC stream merge
  // --------------------------------------------------
  pc_arbiter #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_pc_arbiter (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .head_i     ( pc_head     ),
    .empty_i    ( pc_empty    ),
    .overflow_i ( pc_overflow ),
    .pop_o      ( pc_pop      ),
    .pc_valid_o ( pc_valid_o  ),
    .pc_o       ( pc_o        ),
    .overflow_o ( overflow_o  )
  );

endmodule

//--- tb/trace_checker.sv
// Reference model of the trace unit and per-cycle comparison of all DUT outputs
`timescale 1ns/100ps

module trace_checker #(
  parameter int unsigned NrCommitPorts = trace_pkg::NrCommitPorts,
  parameter int unsigned PcQueueDepth  = trace_pkg::PcQueueDepth
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  trace_pkg::commit_port_t [NrCommitPorts-1:0] commit_i,
  input  trace_pkg::priv_lvl_e                        priv_lvl_i,
  input  logic                                        debug_mode_i,
  input  trace_pkg::trace_rec_t [NrCommitPorts-1:0]   trace_i,
  input  logic                                        pc_valid_i,
  input  trace_pkg::pc_t                              pc_i,
  input  logic                                        overflow_i,
  output int                                          error_count_o,
  output int                                          check_count_o
);

  import trace_pkg::*;

  trace_rec_t exp_rec [NrCommitPorts];
  pc_t        ref_q   [NrCommitPorts][$];
  cycle_t     cycle_cnt   = '0;
  int         rr_ptr      = 0;
  logic       ovf_flag    = 1'b0;
  logic       model_armed = 1'b0;
  int         errors      = 0;
  int         checks      = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  function automatic trace_rec_t expected_record(input commit_port_t c, input priv_lvl_e priv,
                                                 input logic dbg, input cycle_t stamp);
    trace_rec_t r;
    r.valid     = c.ack && !c.ex_valid;
    r.exception = c.ack && c.ex_valid && !c.cause[XLEN-1];
    r.interrupt = c.ack && c.ex_valid && c.cause[XLEN-1];
    r.iaddr     = c.pc;
    r.insn      = c.tval[ILEN-1:0];
    r.cause     = c.cause;
    r.tval      = c.tval;
    r.cycle     = stamp;
    if (dbg) r.mode = MODE_D;
    else if (priv == PRIV_LVL_M) r.mode = MODE_M;
    else if (priv == PRIV_LVL_S) r.mode = MODE_S;
    else r.mode = MODE_U;
    return r;
  endfunction

  // First non-empty queue at or after the pointer or -1 when all are empty
  function automatic int granted_port();
    int cand;
    for (int k = 0; k < int'(NrCommitPorts); k++) begin
      cand = (rr_ptr + k) % int'(NrCommitPorts);
      if (ref_q[cand].size() != 0) return cand;
    end
    return -1;
  endfunction

  task automatic compare_field(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Model update at each rising edge
  // --------------------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    int g;
    if (!rst_ni) begin
      cycle_cnt = '0;
      rr_ptr    = 0;
      ovf_flag  = 1'b0;
      for (int p = 0; p < int'(NrCommitPorts); p++) begin
        exp_rec[p] = '0;
        ref_q[p].delete();
      end
    end else begin
      for (int p = 0; p < int'(NrCommitPorts); p++) begin
        exp_rec[p] = expected_record(commit_i[p], priv_lvl_i, debug_mode_i, cycle_cnt);
      end
      cycle_cnt++;
      // Pop before push so a full queue with a pop takes the new PC
      g = granted_port();
      if (g >= 0) begin
        void'(ref_q[g].pop_front());
        rr_ptr = (g + 1) % int'(NrCommitPorts);
      end
      for (int p = 0; p < int'(NrCommitPorts); p++) begin
        if (commit_i[p].ack && !commit_i[p].ex_valid) begin
          if (ref_q[p].size() < int'(PcQueueDepth)) ref_q[p].push_back(commit_i[p].pc);
          else ovf_flag = 1'b1;
        end
      end
    end
  end

  // Comparison starts once the model has seen a rising edge
  always @(posedge clk_i) begin
    model_armed <= 1'b1;
  end

  // Outputs are settled by the falling edge
  always @(negedge clk_i) begin
    int g;
    if (model_armed) begin
      for (int p = 0; p < int'(NrCommitPorts); p++) begin
        compare_field($sformatf("trace[%0d].valid", p),
                      64'(trace_i[p].valid), 64'(exp_rec[p].valid));
        compare_field($sformatf("trace[%0d].exception", p),
                      64'(trace_i[p].exception), 64'(exp_rec[p].exception));
        compare_field($sformatf("trace[%0d].interrupt", p),
                      64'(trace_i[p].interrupt), 64'(exp_rec[p].interrupt));
        if (exp_rec[p].valid || exp_rec[p].exception || exp_rec[p].interrupt) begin
          compare_field($sformatf("trace[%0d].iaddr", p),
                        64'(trace_i[p].iaddr), 64'(exp_rec[p].iaddr));
          compare_field($sformatf("trace[%0d].insn", p),
                        64'(trace_i[p].insn), 64'(exp_rec[p].insn));
          compare_field($sformatf("trace[%0d].cause", p), trace_i[p].cause, exp_rec[p].cause);
          compare_field($sformatf("trace[%0d].tval", p), trace_i[p].tval, exp_rec[p].tval);
          compare_field($sformatf("trace[%0d].mode", p),
                        64'(trace_i[p].mode), 64'(exp_rec[p].mode));
          compare_field($sformatf("trace[%0d].cycle", p), trace_i[p].cycle, exp_rec[p].cycle);
        end
      end
      g = granted_port();
      compare_field("pc_valid_o", 64'(pc_valid_i), 64'(g >= 0));
      if (g >= 0) begin
        compare_field("pc_o", 64'(pc_i), 64'(ref_q[g][0]));
      end
      compare_field("overflow_o", 64'(overflow_i), 64'(ovf_flag));
    end
  end

endmodule

//--- tb/tb_commit_tracer.sv
// Testbench top: clock, reset, stimulus table, random fill, watchdog, DUT and checker
`timescale 1ns/100ps

module tb_commit_tracer;

  import trace_pkg::*;

  localparam int unsigned NrPorts      = trace_pkg::NrCommitPorts;
  localparam int unsigned QueueDepth   = trace_pkg::PcQueueDepth;
  localparam int          ClkPeriod    = 100;
  localparam int          StimDelay    = 10;
  localparam int          RandomCycles = 200;

  // One table row, written for two commit ports
  typedef struct packed {
    commit_port_t p0;
    commit_port_t p1;
    priv_lvl_e    priv;
    logic         debug;
  } stim_row_t;

  logic                       clk_i;
  logic                       rst_ni;
  commit_port_t [NrPorts-1:0] commit;
  priv_lvl_e                  priv_lvl;
  logic                       debug_mode;
  trace_rec_t [NrPorts-1:0]   trace;
  logic                       pc_valid;
  pc_t                        pc;
  logic                       overflow;
  int                         error_count;
  int                         check_count;

  stim_row_t stim_q[$];
  int        seed = 32'hce25_861f;

  // --------------------------------------------------
  // Row builders
  // --------------------------------------------------
  function automatic commit_port_t idle_port();
    return '0;
  endfunction

  function automatic commit_port_t retire_port(input pc_t pc_val, input instr_t insn);
    commit_port_t c;
    c      = '0;
    c.ack  = 1'b1;
    c.pc   = pc_val;
    c.tval = xlen_t'(insn);
    return c;
  endfunction

  function automatic commit_port_t trap_port(input xlen_t cause, input pc_t pc_val,
                                             input xlen_t tval);
    commit_port_t c;
    c          = '0;
    c.ack      = 1'b1;
    c.ex_valid = 1'b1;
    c.cause    = cause;
    c.pc       = pc_val;
    c.tval     = tval;
    return c;
  endfunction

  task automatic add_row(input commit_port_t p0, input commit_port_t p1,
                         input priv_lvl_e priv, input logic dbg);
    stim_row_t r;
    r.p0    = p0;
    r.p1    = p1;
    r.priv  = priv;
    r.debug = dbg;
    stim_q.push_back(r);
  endtask

  task automatic build_table();
    // Quiet cycles keep every output at its reset value
    add_row(idle_port(), idle_port(), PRIV_LVL_M, 1'b0);
    add_row(idle_port(), idle_port(), PRIV_LVL_M, 1'b0);
    // Single retires on each port, one privilege level each
    add_row(retire_port(39'h00_8000_0000, 32'h0000_0013), idle_port(), PRIV_LVL_M, 1'b0);
    add_row(idle_port(), retire_port(39'h00_8000_0004, 32'h0010_0093), PRIV_LVL_S, 1'b0);
    add_row(retire_port(39'h00_8000_0008, 32'h00a5_0533), idle_port(), PRIV_LVL_U, 1'b0);
    // Exception on port 0, interrupt on port 1
    add_row(trap_port(64'd2, 39'h00_8000_000c, 64'h1234_5678_ffff_ffff),
            trap_port({1'b1, 63'd7}, 39'h00_8000_0010, 64'd0), PRIV_LVL_S, 1'b0);
    // Debug mode hides the privilege level
    add_row(retire_port(39'h00_0000_0800, 32'h7b20_0073),
            retire_port(39'h00_0000_0804, 32'h0000_0013), PRIV_LVL_U, 1'b1);
    add_row(retire_port(39'h00_0000_0808, 32'h0010_0073), idle_port(), PRIV_LVL_M, 1'b1);
    add_row(idle_port(), idle_port(), PRIV_LVL_M, 1'b0);
    add_row(idle_port(), idle_port(), PRIV_LVL_M, 1'b0);
    // Sustained dual retires, two pushes and one pop per cycle
    for (int k = 0; k < 10; k++) begin
      add_row(retire_port(39'h40_0000 + 39'(16 * k), 32'h0000_0013 + 32'(k)),
              retire_port(39'h40_0008 + 39'(16 * k), 32'h0000_0113 + 32'(k)),
              PRIV_LVL_U, 1'b0);
    end
    // Drain, the flag stays up
    for (int k = 0; k < 10; k++) begin
      add_row(idle_port(), idle_port(), PRIV_LVL_M, 1'b0);
    end
  endtask

  task automatic random_row(output stim_row_t r);
    commit_port_t c [2];
    for (int p = 0; p < 2; p++) begin
      c[p]          = '0;
      c[p].ack      = (($random(seed) & 1) != 0);
      c[p].ex_valid = (($random(seed) & 7) == 0);
      c[p].cause    = {$random(seed), $random(seed)};
      c[p].tval     = {$random(seed), $random(seed)};
      c[p].pc       = pc_t'({$random(seed), $random(seed)});
    end
    r.p0 = c[0];
    r.p1 = c[1];
    case ($random(seed) & 3)
      0:       r.priv = PRIV_LVL_U;
      1:       r.priv = PRIV_LVL_S;
      default: r.priv = PRIV_LVL_M;
    endcase
    r.debug = (($random(seed) & 15) == 0);
  endtask

  // --------------------------------------------------
  // Drive helpers
  // --------------------------------------------------
  task automatic apply_row(input stim_row_t row);
    commit[0]  = row.p0;
    commit[1]  = row.p1;
    priv_lvl   = row.priv;
    debug_mode = row.debug;
    @(posedge clk_i);
    #StimDelay;
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    #StimDelay;
    rst_ni = 1'b1;
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  commit_tracer #(
    .NrCommitPorts ( NrPorts    ),
    .PcQueueDepth  ( QueueDepth )
  ) dut (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .commit_i     ( commit     ),
    .priv_lvl_i   ( priv_lvl   ),
    .debug_mode_i ( debug_mode ),
    .trace_o      ( trace      ),
    .pc_valid_o   ( pc_valid   ),
    .pc_o         ( pc         ),
    .overflow_o   ( overflow   )
  );

  trace_checker #(
    .NrCommitPorts ( NrPorts    ),
    .PcQueueDepth  ( QueueDepth )
  ) i_checker (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .commit_i      ( commit      ),
    .priv_lvl_i    ( priv_lvl    ),
    .debug_mode_i  ( debug_mode  ),
    .trace_i       ( trace       ),
    .pc_valid_i    ( pc_valid    ),
    .pc_i          ( pc          ),
    .overflow_i    ( overflow    ),
    .error_count_o ( error_count ),
    .check_count_o ( check_count )
  );

  initial begin : main
    stim_row_t row;
    stim_row_t quiet;
    rst_ni     = 1'b0;
    commit     = '0;
    priv_lvl   = PRIV_LVL_M;
    debug_mode = 1'b0;
    quiet.p0    = idle_port();
    quiet.p1    = idle_port();
    quiet.priv  = PRIV_LVL_M;
    quiet.debug = 1'b0;
    build_table();
    apply_reset();
    foreach (stim_q[k]) begin
      apply_row(stim_q[k]);
    end
    // Sticky overflow clears only here
    apply_reset();
    repeat (RandomCycles) begin
      random_row(row);
      apply_row(row);
    end
    repeat (8) apply_row(quiet);
    $display("Checker summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Run length follows the table size
  initial begin : watchdog
    int unsigned cycles;
    #1;
    cycles = stim_q.size() + RandomCycles + 20;
    #(cycles * ClkPeriod);
    $display("Timeout: run did not finish within %0d clock cycles", cycles);
    $display("Something failed");
    $finish;
  end

endmodule

//--- all.f
rtl/trace_pkg.sv
rtl/trace_encoder.sv
rtl/pc_queue.sv
rtl/pc_arbiter.sv
rtl/commit_tracer.sv
tb/trace_checker.sv
tb/tb_commit_tracer.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_commit_tracer
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Something failed
PASS_MSG  := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi; \
	if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without passing"; exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
